/* Bender.yml */
package:
  name: mem_wb

sources:
  # Design
  - files:
      - mem_pkg.sv
      - cache_access_unit.sv
      - data_ram.sv
      - memory_stage.sv
      - writeback_stage.sv
      - mem_wb_top.sv
  # Testbench
  - target: test
    files:
      - mem_wb_checker.sv
      - mem_tb.sv

/* cache_access_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_access_unit (
   input  logic [1:0]        addr_align_i,
   input  logic [31:0]       core_raw_data_i,
   input  logic [31:0]       cache_raw_data_i,
   input  mem_pkg::op_type_t op_i,
   output logic [3:0]        write_en_o,
   output logic [31:0]       core_normalized_data_o,
   output logic [31:0]       cache_normalized_data_o
);

   import mem_pkg::*;

   logic [7:0]  load_byte;
   logic [15:0] load_half;

   ////////////////////////////////////////////////////////////
   // Store path
   ////////////////////////////////////////////////////////////

   // Replicate the store data across lanes so only the enables
   // depend on the byte offset
   always_comb begin
      core_normalized_data_o = core_raw_data_i;
      write_en_o             = 4'b0000;
      case (op_i)
         OP_SB: begin
            core_normalized_data_o = {4{core_raw_data_i[7:0]}};
            write_en_o             = 4'b0001 << addr_align_i;
         end
         OP_SH: begin
            core_normalized_data_o = {2{core_raw_data_i[15:0]}};
            if (addr_align_i[1]) begin
               write_en_o = 4'b1100;
            end else begin
               write_en_o = 4'b0011;
            end
         end
         OP_SW: begin
            write_en_o = 4'b1111;
         end
         default: begin
            // Loads and bubbles never write
            write_en_o = 4'b0000;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Load path
   ////////////////////////////////////////////////////////////

   // Lane picked by the low address bits
   assign load_byte = cache_raw_data_i[{addr_align_i, 3'b000} +: 8];
   assign load_half = addr_align_i[1] ? cache_raw_data_i[31:16] : cache_raw_data_i[15:0];

   always_comb begin
      case (op_i)
         OP_LB: begin
            cache_normalized_data_o = {{24{load_byte[7]}}, load_byte};
         end
         OP_LBU: begin
            cache_normalized_data_o = {24'h000000, load_byte};
         end
         OP_LH: begin
            cache_normalized_data_o = {{16{load_half[15]}}, load_half};
         end
         OP_LHU: begin
            cache_normalized_data_o = {16'h0000, load_half};
         end
         OP_LW: begin
            cache_normalized_data_o = cache_raw_data_i;
         end
         default: begin
            cache_normalized_data_o = 32'h0000_0000;
         end
      endcase
   end

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
   input  logic              clk_i,
   input  logic              rst_i,
   input  mem_pkg::ram_req_t req_i,
   output logic [31:0]       rdata_o,
   output logic              busywait_o
);

   import mem_pkg::*;

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // One word per entry, split into byte lanes for the enables
   logic [3:0][7:0] mem_q [RAM_DEPTH];

   logic [BUSY_CNT_W-1:0] busy_cnt_q;
   logic                  access_done;

   ////////////////////////////////////////////////////////////
   // Access timing
   ////////////////////////////////////////////////////////////

   // Busy for the first MEM_LATENCY cycles of a request,
   // the access completes in the cycle after that
   assign busywait_o  = req_i.en && (busy_cnt_q != BUSY_CNT_W'(MEM_LATENCY));
   assign access_done = req_i.en && !busywait_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_cnt_q <= '0;
      end else if (busywait_o) begin
         busy_cnt_q <= busy_cnt_q + 1'b1;
      end else begin
         // Completed or idle, next request starts fresh
         busy_cnt_q <= '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read and write ports
   ////////////////////////////////////////////////////////////

   // Combinational read, only meaningful while busywait is low
   assign rdata_o = mem_q[req_i.addr];

   // Write the enabled lanes at the closing edge of the access
   always_ff @(posedge clk_i) begin
      if (access_done) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (req_i.be[lane]) begin
               mem_q[req_i.addr][lane] <= req_i.wdata[8*lane +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* files.f */
mem_pkg.sv
cache_access_unit.sv
data_ram.sv
memory_stage.sv
writeback_stage.sv
mem_wb_top.sv
mem_wb_checker.sv
mem_tb.sv

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

   ////////////////////////////////////////////////////////////
   // Memory geometry and timing
   ////////////////////////////////////////////////////////////

   // Word address width of the data RAM
   localparam int unsigned RAM_ADDR_W = 8;
   localparam int unsigned RAM_DEPTH  = 2 ** RAM_ADDR_W;

   // Stall cycles per access before the RAM completes
   localparam int unsigned MEM_LATENCY = 2;
   localparam int unsigned BUSY_CNT_W  = $clog2(MEM_LATENCY + 1);

   ////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      OP_NONE = 4'd0,
      OP_LB   = 4'd1,
      OP_LH   = 4'd2,
      OP_LW   = 4'd3,
      OP_LBU  = 4'd4,
      OP_LHU  = 4'd5,
      OP_SB   = 4'd6,
      OP_SH   = 4'd7,
      OP_SW   = 4'd8
   } op_type_t;

   // Source of the register file write value
   typedef enum logic [1:0] {
      WB_ALU  = 2'd0,
      WB_LOAD = 2'd1,
      WB_IMM  = 2'd2,
      WB_PC4  = 2'd3
   } wb_sel_t;

   ////////////////////////////////////////////////////////////
   // Pipeline records
   ////////////////////////////////////////////////////////////

   // Record from execute into the memory stage
   typedef struct packed {
      op_type_t    op;
      logic        reg_wb_en;
      logic [4:0]  rd;
      logic [31:0] alu_out;
      wb_sel_t     wb_sel;
      logic [31:0] imm;
      logic [31:0] pc;
      logic        is_mem;
      logic [31:0] rs2_data;
   } ex_mem_t;

   // Registered record between memory and writeback
   typedef struct packed {
      logic        reg_wb_en;
      logic [4:0]  rd;
      logic [31:0] alu_out;
      wb_sel_t     wb_sel;
      logic [31:0] imm;
      logic [31:0] pc;
      logic [31:0] load_val;
   } mem_wb_t;

   // Register file write port
   typedef struct packed {
      logic        en;
      logic [4:0]  rd;
      logic [31:0] data;
   } wb_t;

   // Data RAM request, addr is a word address
   typedef struct packed {
      logic                  en;
      logic [RAM_ADDR_W-1:0] addr;
      logic [31:0]           wdata;
      logic [3:0]            be;
   } ram_req_t;

endpackage

`default_nettype wire

/* mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_tb;

   import mem_pkg::*;

   localparam int unsigned WAIT_LIMIT = 20;
   localparam int unsigned WIN_WORDS  = 64;
   localparam int unsigned BYTE_AW    = RAM_ADDR_W + 2;

   // Expected writeback and the cycle it is due in
   typedef struct packed {
      wb_t         wb;
      logic [31:0] due;
   } exp_t;

   logic    clk_i = 1'b0;
   logic    rst_i;
   ex_mem_t ex_mem_i;
   logic    busywait_o;
   wb_t     wb_o;

   logic [7:0]  ref_mem [RAM_DEPTH*4];
   exp_t        exp_q [$];
   logic [31:0] cycle_cnt    = '0;
   logic        wb_held      = 1'b0;
   wb_t         last_wb      = '0;
   string       test_name    = "reset";
   int unsigned check_errs   = 0;
   int unsigned timing_errs  = 0;
   int unsigned timeout_errs = 0;
   op_type_t    ld_ops [5]   = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
   op_type_t    st_ops [3]   = '{OP_SB, OP_SH, OP_SW};

   mem_wb_top dut0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ex_mem_i   (ex_mem_i),
      .busywait_o (busywait_o),
      .wb_o       (wb_o)
   );

   always #2 clk_i = ~clk_i;

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] load_ref(op_type_t op, logic [BYTE_AW-1:0] a);
      logic [7:0]  b;
      logic [15:0] h;
      b = ref_mem[a];
      h = {ref_mem[{a[BYTE_AW-1:1], 1'b1}], ref_mem[{a[BYTE_AW-1:1], 1'b0}]};
      case (op)
         OP_LB:   return {{24{b[7]}}, b};
         OP_LBU:  return {24'd0, b};
         OP_LH:   return {{16{h[15]}}, h};
         OP_LHU:  return {16'd0, h};
         default: return {ref_mem[{a[BYTE_AW-1:2], 2'd3}], ref_mem[{a[BYTE_AW-1:2], 2'd2}],
                          ref_mem[{a[BYTE_AW-1:2], 2'd1}], ref_mem[{a[BYTE_AW-1:2], 2'd0}]};
      endcase
   endfunction

   function automatic void store_ref(op_type_t op, logic [BYTE_AW-1:0] a, logic [31:0] d);
      case (op)
         OP_SB: ref_mem[a] = d[7:0];
         OP_SH: begin
            ref_mem[{a[BYTE_AW-1:1], 1'b0}] = d[7:0];
            ref_mem[{a[BYTE_AW-1:1], 1'b1}] = d[15:8];
         end
         OP_SW: begin
            for (int i = 0; i < 4; i++) begin
               ref_mem[{a[BYTE_AW-1:2], 2'(i)}] = d[8*i +: 8];
            end
         end
         default: ;
      endcase
   endfunction

   // Natural alignment for half and word accesses
   function automatic logic [31:0] align(op_type_t op, logic [31:0] a);
      if (op inside {OP_LH, OP_LHU, OP_SH}) begin
         return {a[31:1], 1'b0};
      end else if (op inside {OP_LW, OP_SW}) begin
         return {a[31:2], 2'b00};
      end
      return a;
   endfunction

   function automatic ex_mem_t mem_rec(op_type_t op, logic [31:0] addr, logic [4:0] rd,
                                       logic [31:0] data);
      ex_mem_t r;
      r           = '0;
      r.op        = op;
      r.is_mem    = 1'b1;
      r.reg_wb_en = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
      r.rd        = rd;
      r.alu_out   = align(op, addr);
      r.wb_sel    = r.reg_wb_en ? WB_LOAD : WB_ALU;
      r.rs2_data  = data;
      r.pc        = 32'h0000_1000 + addr;
      return r;
   endfunction

   function automatic ex_mem_t alu_rec(wb_sel_t sel, logic en, logic [4:0] rd, logic [31:0] val);
      ex_mem_t r;
      r           = '0;
      r.op        = OP_NONE;
      r.reg_wb_en = en;
      r.rd        = rd;
      r.alu_out   = val;
      r.wb_sel    = sel;
      r.imm       = val ^ 32'h5a5a_0ff0;
      r.pc        = {val[31:2], 2'b00};
      return r;
   endfunction

   ////////////////////////////////////////////////////////////
   // Issue and drain
   ////////////////////////////////////////////////////////////

   // Drive one record, queue its writeback, hold it through the stall
   task automatic send(input ex_mem_t rec);
      exp_t        e;
      int unsigned waited;
      e.wb.en = rec.reg_wb_en && (rec.rd != 5'd0);
      e.wb.rd = rec.rd;
      case (rec.wb_sel)
         WB_ALU:  e.wb.data = rec.alu_out;
         WB_LOAD: e.wb.data = load_ref(rec.op, rec.alu_out[BYTE_AW-1:0]);
         WB_IMM:  e.wb.data = rec.imm;
         default: e.wb.data = rec.pc + 32'd4;
      endcase
      store_ref(rec.op, rec.alu_out[BYTE_AW-1:0], rec.rs2_data);
      @(negedge clk_i);
      ex_mem_i = rec;
      e.due    = cycle_cnt + (rec.is_mem ? (MEM_LATENCY + 1) : 1);
      if (e.wb.en) begin
         exp_q.push_back(e);
      end
      waited = 0;
      #1;
      while (busywait_o) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            timeout_errs++;
            $display("Timeout: busywait stayed high for %0d cycles in %s", waited, test_name);
            break;
         end
         @(negedge clk_i);
         #1;
      end
   endtask

   task automatic wait_drain();
      int unsigned waited;
      @(negedge clk_i);
      ex_mem_i = '0;
      waited   = 0;
      while (exp_q.size() != 0) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            timeout_errs++;
            $display("Timeout: %0d writebacks never arrived in %s", exp_q.size(), test_name);
            exp_q.delete();
            break;
         end
         @(negedge clk_i);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Writeback scoreboard
   ////////////////////////////////////////////////////////////

   // A stall freezes mem_wb, so the same write repeats until the next record loads
   always @(posedge clk_i) begin : scoreboard
      exp_t head;
      if (!rst_i && wb_o.en) begin
         if (wb_held) begin
            wb_hold_a: assert (wb_o == last_wb) else begin
               check_errs++;
               $display("[FAIL] %s: expected held x%0d=%08h, actual x%0d=%08h", test_name,
                        last_wb.rd, last_wb.data, wb_o.rd, wb_o.data);
            end
         end else if (exp_q.size() == 0) begin
            check_errs++;
            $display("Writeback to x%0d arrived with nothing expected in %s", wb_o.rd, test_name);
         end else begin
            head    = exp_q.pop_front();
            last_wb = head.wb;
            wb_match_a: assert (wb_o == head.wb) else begin
               check_errs++;
               $display("[FAIL] %s: expected x%0d=%08h, actual x%0d=%08h", test_name,
                        head.wb.rd, head.wb.data, wb_o.rd, wb_o.data);
            end
            wb_time_a: assert (cycle_cnt == head.due) else begin
               timing_errs++;
               $display("[FAIL] %s: expected cycle %0d, actual cycle %0d", test_name,
                        head.due, cycle_cnt);
            end
         end
      end
      wb_held   = busywait_o;
      cycle_cnt = cycle_cnt + 1;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      logic [31:0] addr;
      op_type_t    op;
      wb_sel_t     sel;
      void'($urandom(32'h7a8d));
      rst_i    = 1'b1;
      ex_mem_i = '0;
      repeat (4) @(negedge clk_i);
      rst_i = 1'b0;

      // Pattern built from the whole word address
      test_name = "prefill";
      for (int w = 0; w < WIN_WORDS; w++) begin
         send(mem_rec(OP_SW, 32'(w) << 2, 5'd0, {8'(w), 8'(~w), 8'(w ^ 8'h5a), 8'(w + 3)}));
      end

      test_name = "word store and load";
      for (int i = 0; i < 4; i++) begin
         r = $urandom();
         send(mem_rec(OP_SW, 32'h40 + 32'(i * 12), 5'd0, r));
         send(mem_rec(OP_LW, 32'h40 + 32'(i * 12), 5'(i + 1), 32'd0));
      end

      test_name = "byte and half merge";
      for (int i = 0; i < 4; i++) begin
         send(mem_rec(OP_SB, 32'h80 + 32'(i), 5'd0, $urandom() | {24'd0, i[0], 7'd0}));
         send(mem_rec(OP_LB, 32'h80 + 32'(i), 5'd5, 32'd0));
         send(mem_rec(OP_LBU, 32'h80 + 32'(i), 5'd6, 32'd0));
      end
      for (int i = 0; i < 4; i += 2) begin
         send(mem_rec(OP_SH, 32'h90 + 32'(i), 5'd0, $urandom()));
         send(mem_rec(OP_LH, 32'h90 + 32'(i), 5'd7, 32'd0));
         send(mem_rec(OP_LHU, 32'h90 + 32'(i), 5'd8, 32'd0));
      end
      send(mem_rec(OP_LW, 32'h80, 5'd9, 32'd0));
      send(mem_rec(OP_LW, 32'h90, 5'd9, 32'd0));

      test_name = "non-memory select";
      r = $urandom();
      send(alu_rec(WB_ALU, 1'b1, 5'd10, r));
      send(alu_rec(WB_IMM, 1'b1, 5'd11, r));
      send(alu_rec(WB_PC4, 1'b1, 5'd12, r));
      send(alu_rec(WB_ALU, 1'b1, 5'd0, r));
      send(alu_rec(WB_IMM, 1'b0, 5'd13, r));

      test_name = "load then alu order";
      send(mem_rec(OP_LW, 32'h44, 5'd14, 32'd0));
      send(alu_rec(WB_ALU, 1'b1, 5'd15, $urandom()));
      send(alu_rec(WB_PC4, 1'b1, 5'd16, $urandom()));
      send(mem_rec(OP_LH, 32'h86, 5'd17, 32'd0));
      send(alu_rec(WB_IMM, 1'b1, 5'd18, $urandom()));

      test_name = "random mix";
      for (int n = 0; n < 200; n++) begin
         addr = $urandom_range(WIN_WORDS * 4 - 1);
         r    = $urandom();
         case ($urandom_range(5))
            0: send(alu_rec(WB_ALU, 1'b0, 5'd0, 32'd0));
            1, 2: begin
               sel = wb_sel_t'($urandom_range(3));
               if (sel == WB_LOAD) begin
                  sel = WB_ALU;
               end
               send(alu_rec(sel, 1'($urandom()), 5'($urandom()), r));
            end
            3, 4: begin
               op = ld_ops[$urandom_range(4)];
               send(mem_rec(op, addr, 5'($urandom()), 32'd0));
            end
            default: begin
               op = st_ops[$urandom_range(2)];
               send(mem_rec(op, addr, 5'd0, r));
            end
         endcase
      end
      wait_drain();

      // Reset while a load stalls behind a pending write,
      // upstream keeps the load until reset is released
      test_name = "reset during stall";
      send(alu_rec(WB_ALU, 1'b1, 5'd19, $urandom()));
      @(negedge clk_i);
      ex_mem_i = mem_rec(OP_LW, 32'h44, 5'd20, 32'd0);
      @(negedge clk_i);
      rst_i = 1'b1;
      repeat (2) @(negedge clk_i);
      rst_i    = 1'b0;
      ex_mem_i = '0;
      #1;
      reset_idle_a: assert (!wb_o.en && !busywait_o) else begin
         check_errs++;
         $display("[FAIL] %s: expected en=0 busy=0, actual en=%0b busy=%0b", test_name,
                  wb_o.en, busywait_o);
      end
      send(alu_rec(WB_ALU, 1'b1, 5'd21, $urandom()));
      wait_drain();

      repeat (2) @(negedge clk_i);
      $display("Errors: %0d value, %0d timing, %0d timeout, %0d assertion", check_errs,
               timing_errs, timeout_errs, dut0.chk0.fail_cnt);
      if (check_errs + timing_errs + timeout_errs + dut0.chk0.fail_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* mem_wb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_checker (
   input logic         clk_i,
   input logic         rst_i,
   input logic         busywait_i,
   input mem_pkg::wb_t wb_i
);

   import mem_pkg::*;

   // Failures seen so far, read at the end of the run
   int unsigned fail_cnt = 0;

   ////////////////////////////////////////////////////////////
   // Protocol properties
   ////////////////////////////////////////////////////////////

   // Both stages come out of reset empty and idle
   reset_idle_a: assert property (@(posedge clk_i) $fell(rst_i) |-> !wb_i.en && !busywait_i)
      else begin
         $error("Writeback or stall active in the cycle after reset");
         fail_cnt++;
      end

   // Stall never outlasts the RAM latency
   stall_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
      busywait_i [*MEM_LATENCY] |=> !busywait_i)
      else begin
         $error("busywait high for more than %0d cycles", MEM_LATENCY);
         fail_cnt++;
      end

   // x0 is never a write target
   no_x0_write_a: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_i.en |-> wb_i.rd != 5'd0)
      else begin
         $error("Register write enabled for x0");
         fail_cnt++;
      end

endmodule

bind mem_wb_top mem_wb_checker chk0 (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .busywait_i (busywait_o),
   .wb_i       (wb_o)
);

`default_nettype wire

/* mem_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top (
   input  logic             clk_i,
   input  logic             rst_i,
   input  mem_pkg::ex_mem_t ex_mem_i,
   output logic             busywait_o,
   output mem_pkg::wb_t     wb_o
);

   import mem_pkg::*;

   ram_req_t    ram_req;
   logic [31:0] ram_rdata;
   mem_wb_t     mem_wb;

   ////////////////////////////////////////////////////////////
   // Memory stage and data RAM
   ////////////////////////////////////////////////////////////

   memory_stage mem_stage0 (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .ex_mem_i       (ex_mem_i),
      .ram_busywait_i (busywait_o),
      .ram_rdata_i    (ram_rdata),
      .ram_req_o      (ram_req),
      .mem_wb_o       (mem_wb)
   );

   // RAM stall doubles as the stall seen by upstream
   data_ram ram0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (ram_req),
      .rdata_o    (ram_rdata),
      .busywait_o (busywait_o)
   );

   ////////////////////////////////////////////////////////////
   // Writeback
   ////////////////////////////////////////////////////////////

   writeback_stage wb_stage0 (
      .mem_wb_i (mem_wb),
      .wb_o     (wb_o)
   );

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
   input  logic              clk_i,
   input  logic              rst_i,
   input  mem_pkg::ex_mem_t  ex_mem_i,
   input  logic              ram_busywait_i,
   input  logic [31:0]       ram_rdata_i,
   output mem_pkg::ram_req_t ram_req_o,
   output mem_pkg::mem_wb_t  mem_wb_o
);

   import mem_pkg::*;

   logic [31:0] store_data;
   logic [3:0]  store_be;
   logic [31:0] load_val;

   mem_wb_t mem_wb_d;
   mem_wb_t mem_wb_q;

   ////////////////////////////////////////////////////////////
   // Data alignment
   ////////////////////////////////////////////////////////////

   cache_access_unit cau0 (
      .addr_align_i            (ex_mem_i.alu_out[1:0]),
      .core_raw_data_i         (ex_mem_i.rs2_data),
      .cache_raw_data_i        (ram_rdata_i),
      .op_i                    (ex_mem_i.op),
      .write_en_o              (store_be),
      .core_normalized_data_o  (store_data),
      .cache_normalized_data_o (load_val)
   );

   ////////////////////////////////////////////////////////////
   // RAM request
   ////////////////////////////////////////////////////////////

   // Word address taken from the ALU result, low bits select lanes
   always_comb begin
      ram_req_o.en    = ex_mem_i.is_mem;
      ram_req_o.addr  = ex_mem_i.alu_out[RAM_ADDR_W+1:2];
      ram_req_o.wdata = store_data;
      ram_req_o.be    = store_be;
   end

   ////////////////////////////////////////////////////////////
   // Memory / writeback register
   ////////////////////////////////////////////////////////////

   always_comb begin
      mem_wb_d.reg_wb_en = ex_mem_i.reg_wb_en;
      mem_wb_d.rd        = ex_mem_i.rd;
      mem_wb_d.alu_out   = ex_mem_i.alu_out;
      mem_wb_d.wb_sel    = ex_mem_i.wb_sel;
      mem_wb_d.imm       = ex_mem_i.imm;
      mem_wb_d.pc        = ex_mem_i.pc;
      mem_wb_d.load_val  = load_val;
   end

   // Hold the previous record while the RAM stalls
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mem_wb_q <= '0;
      end else if (!ram_busywait_i) begin
         mem_wb_q <= mem_wb_d;
      end
   end

   assign mem_wb_o = mem_wb_q;

endmodule

`default_nettype wire

/* writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
   input  mem_pkg::mem_wb_t mem_wb_i,
   output mem_pkg::wb_t     wb_o
);

   import mem_pkg::*;

   logic [31:0] pc_plus4;

   assign pc_plus4 = mem_wb_i.pc + 32'd4;

   // Pick the write value by source select
   always_comb begin
      case (mem_wb_i.wb_sel)
         WB_ALU: begin
            wb_o.data = mem_wb_i.alu_out;
         end
         WB_LOAD: begin
            wb_o.data = mem_wb_i.load_val;
         end
         WB_IMM: begin
            wb_o.data = mem_wb_i.imm;
         end
         default: begin
            // WB_PC4, return address for jumps
            wb_o.data = pc_plus4;
         end
      endcase
   end

   // x0 is hardwired to zero, never write it
   assign wb_o.en = mem_wb_i.reg_wb_en && (mem_wb_i.rd != 5'd0);
   assign wb_o.rd = mem_wb_i.rd;

endmodule

`default_nettype wire
